// ==== iw_conv_pkg.sv ====
package iw_conv_pkg;

  // Width of the wide ID seen on the slave side of the converter
  localparam int unsigned SLV_ID_W = 6;

  // Width of the short ID sent to the downstream master port
  localparam int unsigned MST_ID_W = 2;

  // One remap entry exists for every short ID value
  // The short ID is the entry index itself
  localparam int unsigned NUM_ENTRIES = 2 ** MST_ID_W;

  // Reads with the same wide ID that may be outstanding at once
  // Further reads with that ID wait until one of them retires
  localparam int unsigned MAX_TXNS_PER_ID = 3;

  // Counter width needed to hold 0 up to MAX_TXNS_PER_ID
  localparam int unsigned CNT_W = $clog2(MAX_TXNS_PER_ID + 1);

  // Address and data widths are the same on both ports
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // AXI burst length field, number of beats minus one
  localparam int unsigned LEN_W = 8;

  // Wide ID as carried on slave AR and slave R
  typedef logic [SLV_ID_W-1:0] slv_id_t;

  // Short ID as carried on master AR and master R
  // It also selects the entry in the remap table
  typedef logic [MST_ID_W-1:0] mst_id_t;

  // Channel payload fields
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LEN_W-1:0]  len_t;

  // Outstanding read count of one table entry
  typedef logic [CNT_W-1:0] cnt_t;

endpackage

// ==== remap_alloc_if.sv ====
`timescale 1ns/1ps

// Allocation path between the AR stage and the remap table
// The stage asks for a short ID for a given wide ID
// The table answers in the same cycle with a grant and the entry index
// The allocation is taken on the cycle where req and gnt are both high
interface remap_alloc_if
  import iw_conv_pkg::*;
();

  // Request for a short ID, raised while a slave AR waits to be taken
  logic    req;

  // Wide ID of the waiting slave AR
  slv_id_t slv_id;

  // The table can take the request in this cycle
  logic    gnt;

  // Entry that serves the request, used as the master AR ID
  mst_id_t idx;

  // Side of the AR stage
  modport stage (
    output req,
    output slv_id,
    input  gnt,
    input  idx
  );

  // Side of the remap table
  modport tbl (
    input  req,
    input  slv_id,
    output gnt,
    output idx
  );

endinterface

// ==== id_remap_table.sv ====
`timescale 1ns/1ps

// Table of wide IDs that currently have reads in flight
// Each entry holds an occupied flag, the wide ID and the number of open bursts
// The entry index is the short ID used on the master side
module id_remap_table
  import iw_conv_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  remap_alloc_if.tbl  alloc,
  input  mst_id_t     lookup_idx_i,
  output slv_id_t     lookup_slv_id_o,
  input  logic        retire_i
);

  // Entry state
  logic [NUM_ENTRIES-1:0] occ_q;
  slv_id_t                id_q  [NUM_ENTRIES];
  cnt_t                   cnt_q [NUM_ENTRIES];

  // Search results for the current request
  logic    match_found;
  mst_id_t match_idx;
  logic    free_found;
  mst_id_t free_idx;

  // Per-entry increment and decrement strobes
  logic                   alloc_fire;
  logic [NUM_ENTRIES-1:0] inc_sel;
  logic [NUM_ENTRIES-1:0] dec_sel;

  // Scan all entries once
  // The first match and the first free entry in index order are kept,
  // so the lowest free entry wins when a new wide ID arrives
  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    free_found  = 1'b0;
    free_idx    = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (occ_q[i] && (id_q[i] == alloc.slv_id) && !match_found) begin
        match_found = 1'b1;
        match_idx   = mst_id_t'(i);
      end
      if (!occ_q[i] && !free_found) begin
        free_found = 1'b1;
        free_idx   = mst_id_t'(i);
      end
    end
  end

  // A wide ID already in the table must stay on its own entry
  // so that its bursts keep their order on the master side
  // When that entry is full the request waits, even if other entries are free
  always_comb begin
    if (match_found) begin
      alloc.gnt = (cnt_q[match_idx] != cnt_t'(MAX_TXNS_PER_ID));
      alloc.idx = match_idx;
    end else begin
      alloc.gnt = free_found;
      alloc.idx = free_idx;
    end
  end

  assign alloc_fire = alloc.req && alloc.gnt;

  // Decode which entry gains a burst and which one loses a burst
  // A retire is only counted on an occupied entry so a stray beat cannot wrap the count
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      inc_sel[i] = alloc_fire && (alloc.idx == mst_id_t'(i));
      dec_sel[i] = retire_i && occ_q[i] && (lookup_idx_i == mst_id_t'(i));
    end
  end

  // Counts and occupied flags
  // Allocation and retirement on the same entry cancel out
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      occ_q <= '0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (inc_sel[i] && !dec_sel[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
          occ_q[i] <= 1'b1;
        end else if (dec_sel[i] && !inc_sel[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
          // Last open burst of this wide ID is done
          if (cnt_q[i] == cnt_t'(1)) begin
            occ_q[i] <= 1'b0;
          end
        end
      end
    end
  end

  // The wide ID is written when a free entry is claimed
  // It is only read while the entry is occupied
  always_ff @(posedge clk_i) begin
    if (alloc_fire && !occ_q[alloc.idx]) begin
      id_q[alloc.idx] <= alloc.slv_id;
    end
  end

  // Wide ID for a returning R beat
  assign lookup_slv_id_o = id_q[lookup_idx_i];

endmodule

// ==== ar_remap_stage.sv ====
`timescale 1ns/1ps

// AR path of the converter
// A slave AR is taken once the table grants a short ID for its wide ID
// The beat then sits in an output register that drives the master AR
module ar_remap_stage
  import iw_conv_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,

  // Slave-side AR
  input  logic          slv_ar_valid_i,
  output logic          slv_ar_ready_o,
  input  slv_id_t       slv_ar_id_i,
  input  addr_t         slv_ar_addr_i,
  input  len_t          slv_ar_len_i,

  // Short ID allocation
  remap_alloc_if.stage  alloc,

  // Master-side AR
  output logic          mst_ar_valid_o,
  input  logic          mst_ar_ready_i,
  output mst_id_t       mst_ar_id_o,
  output addr_t         mst_ar_addr_o,
  output len_t          mst_ar_len_o
);

  // The output register can take a beat in this cycle
  logic    reg_open;

  // A slave AR transfers in this cycle
  logic    ar_accept;

  // Output register
  logic    mst_valid_q;
  mst_id_t mst_id_q;
  addr_t   mst_addr_q;
  len_t    mst_len_q;

  // The register is free when empty, or when its beat leaves in this cycle
  assign reg_open = !mst_valid_q || mst_ar_ready_i;

  // Only ask for a short ID when the beat could actually be stored,
  // otherwise the table would count a burst that never went out
  assign alloc.req    = slv_ar_valid_i && reg_open;
  assign alloc.slv_id = slv_ar_id_i;

  assign slv_ar_ready_o = alloc.gnt && reg_open;
  assign ar_accept      = slv_ar_valid_i && slv_ar_ready_o;

  // Valid bit of the output register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mst_valid_q <= 1'b0;
    end else if (ar_accept) begin
      mst_valid_q <= 1'b1;
    end else if (mst_ar_ready_i) begin
      // Beat taken by the master and nothing new behind it
      mst_valid_q <= 1'b0;
    end
  end

  // Payload of the output register
  // The granted entry index becomes the master AR ID
  always_ff @(posedge clk_i) begin
    if (ar_accept) begin
      mst_id_q   <= alloc.idx;
      mst_addr_q <= slv_ar_addr_i;
      mst_len_q  <= slv_ar_len_i;
    end
  end

  assign mst_ar_valid_o = mst_valid_q;
  assign mst_ar_id_o    = mst_id_q;
  assign mst_ar_addr_o  = mst_addr_q;
  assign mst_ar_len_o   = mst_len_q;

endmodule

// ==== r_restore_stage.sv ====
`timescale 1ns/1ps

// R path of the converter
// Beats pass straight through with no storage
// The short ID of each beat is looked up in the table and replaced by the wide ID
module r_restore_stage
  import iw_conv_pkg::*;
(
  // Master-side R
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  input  mst_id_t mst_r_id_i,
  input  data_t   mst_r_data_i,
  input  logic    mst_r_last_i,

  // Slave-side R
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  output slv_id_t slv_r_id_o,
  output data_t   slv_r_data_o,
  output logic    slv_r_last_o,

  // Table lookup and retirement
  output mst_id_t lookup_idx_o,
  input  slv_id_t lookup_slv_id_i,
  output logic    retire_o
);

  // A beat transfers on the slave side in this cycle
  logic r_fire;

  // Handshake goes through unchanged in both directions
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;

  // The short ID addresses the table entry of this burst
  assign lookup_idx_o = mst_r_id_i;

  // Restore the wide ID, keep data and last as they are
  assign slv_r_id_o   = lookup_slv_id_i;
  assign slv_r_data_o = mst_r_data_i;
  assign slv_r_last_o = mst_r_last_i;

  assign r_fire = mst_r_valid_i && slv_r_ready_i;

  // One burst is complete when its last beat has been handed over
  // The table uses the same lookup index to find the entry to retire
  assign retire_o = r_fire && mst_r_last_i;

endmodule

// ==== iw_converter.sv ====
`timescale 1ns/1ps

// Read-path ID width converter
// Wide slave IDs are remapped to short master IDs on AR
// and restored on R from a table of in-flight IDs
module iw_converter
  import iw_conv_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,

  // Slave-side AR
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  input  slv_id_t slv_ar_id_i,
  input  addr_t   slv_ar_addr_i,
  input  len_t    slv_ar_len_i,

  // Slave-side R
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  output slv_id_t slv_r_id_o,
  output data_t   slv_r_data_o,
  output logic    slv_r_last_o,

  // Master-side AR
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  output mst_id_t mst_ar_id_o,
  output addr_t   mst_ar_addr_o,
  output len_t    mst_ar_len_o,

  // Master-side R
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  input  mst_id_t mst_r_id_i,
  input  data_t   mst_r_data_i,
  input  logic    mst_r_last_i
);

  // Lookup and retirement between the R stage and the table
  mst_id_t lookup_idx;
  slv_id_t lookup_slv_id;
  logic    retire;

  // Allocation between the AR stage and the table
  remap_alloc_if alloc_if ();

  ar_remap_stage i_ar_stage (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_ar_id_i    ( slv_ar_id_i    ),
    .slv_ar_addr_i  ( slv_ar_addr_i  ),
    .slv_ar_len_i   ( slv_ar_len_i   ),
    .alloc          ( alloc_if       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_ar_id_o    ( mst_ar_id_o    ),
    .mst_ar_addr_o  ( mst_ar_addr_o  ),
    .mst_ar_len_o   ( mst_ar_len_o   )
  );

  id_remap_table i_table (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .alloc           ( alloc_if      ),
    .lookup_idx_i    ( lookup_idx    ),
    .lookup_slv_id_o ( lookup_slv_id ),
    .retire_i        ( retire        )
  );

  r_restore_stage i_r_stage (
    .mst_r_valid_i   ( mst_r_valid_i ),
    .mst_r_ready_o   ( mst_r_ready_o ),
    .mst_r_id_i      ( mst_r_id_i    ),
    .mst_r_data_i    ( mst_r_data_i  ),
    .mst_r_last_i    ( mst_r_last_i  ),
    .slv_r_valid_o   ( slv_r_valid_o ),
    .slv_r_ready_i   ( slv_r_ready_i ),
    .slv_r_id_o      ( slv_r_id_o    ),
    .slv_r_data_o    ( slv_r_data_o  ),
    .slv_r_last_o    ( slv_r_last_o  ),
    .lookup_idx_o    ( lookup_idx    ),
    .lookup_slv_id_i ( lookup_slv_id ),
    .retire_o        ( retire        )
  );

endmodule

// ==== tb_iw_converter.sv ====
`timescale 1ns/1ps

// Directed testbench for the read-path ID width converter
// A small master-side memory model answers every master AR with an R burst
module tb_iw_converter
  import iw_conv_pkg::*;
();

  // Cycles any single wait may take before the run is stopped
  localparam int WAIT_LIMIT = 64;

  logic    clk;
  logic    rst;

  // Slave side
  logic    slv_ar_valid;
  logic    slv_ar_ready;
  slv_id_t slv_ar_id;
  addr_t   slv_ar_addr;
  len_t    slv_ar_len;
  logic    slv_r_valid;
  logic    slv_r_ready;
  slv_id_t slv_r_id;
  data_t   slv_r_data;
  logic    slv_r_last;

  // Master side
  logic    mst_ar_valid;
  logic    mst_ar_ready;
  mst_id_t mst_ar_id;
  addr_t   mst_ar_addr;
  len_t    mst_ar_len;
  logic    mst_r_valid;
  logic    mst_r_ready;
  mst_id_t mst_r_id;
  data_t   mst_r_data;
  logic    mst_r_last;

  int          err_count;
  int          check_count;
  logic [31:0] lfsr_q;

  // Slave ARs in the order they were issued
  slv_id_t iss_wide_q[$];
  addr_t   iss_addr_q[$];
  len_t    iss_len_q[$];

  // Master ARs in the order the memory model saw them
  mst_id_t seen_id_q[$];
  addr_t   seen_addr_q[$];
  len_t    seen_len_q[$];

  iw_converter dut (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_ready_o ( slv_ar_ready ),
    .slv_ar_id_i    ( slv_ar_id    ),
    .slv_ar_addr_i  ( slv_ar_addr  ),
    .slv_ar_len_i   ( slv_ar_len   ),
    .slv_r_valid_o  ( slv_r_valid  ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .slv_r_id_o     ( slv_r_id     ),
    .slv_r_data_o   ( slv_r_data   ),
    .slv_r_last_o   ( slv_r_last   ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_ar_id_o    ( mst_ar_id    ),
    .mst_ar_addr_o  ( mst_ar_addr  ),
    .mst_ar_len_o   ( mst_ar_len   ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_ready_o  ( mst_r_ready  ),
    .mst_r_id_i     ( mst_r_id     ),
    .mst_r_data_i   ( mst_r_data   ),
    .mst_r_last_i   ( mst_r_last   )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Memory model records each master AR that transfers on the next rising edge
  always @(negedge clk) begin
    if (!rst && mst_ar_valid && mst_ar_ready) begin
      seen_id_q.push_back(mst_ar_id);
      seen_addr_q.push_back(mst_ar_addr);
      seen_len_q.push_back(mst_ar_len);
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        out_bit;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr_q[0];
      lfsr_q  = lfsr_q >> 1;
      if (out_bit) begin
        lfsr_q = lfsr_q ^ 32'h8020_0003;
      end
      val = {val[30:0], out_bit};
    end
    return val;
  endfunction

  // Read data of the memory model for one beat of a burst
  function automatic data_t beat_data(input addr_t addr, input int beat);
    return data_t'((addr + addr_t'(beat * 4)) ^ 32'hC3C3_0000);
  endfunction

  task automatic finish_run();
    $display("Checks run %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("Timeout while waiting for %s", what);
    err_count++;
    finish_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_ar(input mst_id_t got_id, input mst_id_t exp_id,
                          input addr_t got_addr, input addr_t exp_addr,
                          input len_t got_len, input len_t exp_len);
    check_count++;
    if (got_id !== exp_id) begin
      $display("[FAIL] mst_ar_id got %h expected %h", got_id, exp_id);
      err_count++;
    end
    if (got_addr !== exp_addr) begin
      $display("[FAIL] mst_ar_addr got %h expected %h", got_addr, exp_addr);
      err_count++;
    end
    if (got_len !== exp_len) begin
      $display("[FAIL] mst_ar_len got %h expected %h", got_len, exp_len);
      err_count++;
    end
  endtask

  task automatic check_r(input slv_id_t got_id, input slv_id_t exp_id,
                         input data_t got_data, input data_t exp_data,
                         input logic got_last, input logic exp_last);
    check_count++;
    if (got_id !== exp_id) begin
      $display("[FAIL] slv_r_id got %h expected %h", got_id, exp_id);
      err_count++;
    end
    if (got_data !== exp_data) begin
      $display("[FAIL] slv_r_data got %h expected %h", got_data, exp_data);
      err_count++;
    end
    if (got_last !== exp_last) begin
      $display("[FAIL] slv_r_last got %h expected %h", got_last, exp_last);
      err_count++;
    end
  endtask

  task automatic clear_books();
    iss_wide_q.delete();
    iss_addr_q.delete();
    iss_len_q.delete();
    seen_id_q.delete();
    seen_addr_q.delete();
    seen_len_q.delete();
  endtask

  // Raise a slave AR and keep it up until wait_ar_accept sees the transfer
  task automatic drive_ar(input slv_id_t id, input addr_t addr, input len_t len);
    @(posedge clk);
    slv_ar_valid <= 1'b1;
    slv_ar_id    <= id;
    slv_ar_addr  <= addr;
    slv_ar_len   <= len;
    iss_wide_q.push_back(id);
    iss_addr_q.push_back(addr);
    iss_len_q.push_back(len);
  endtask

  task automatic wait_ar_accept();
    int t;
    t = 0;
    @(negedge clk);
    while (!slv_ar_ready) begin
      t++;
      if (t == WAIT_LIMIT) begin
        timed_out("slave AR ready");
      end
      @(negedge clk);
    end
    @(posedge clk);
    slv_ar_valid <= 1'b0;
  endtask

  // The pending slave AR must not be taken for this many cycles
  task automatic expect_ar_stall(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      check_bit("slv_ar_ready", slv_ar_ready, 1'b0);
    end
  endtask

  task automatic wait_seen(input int n);
    int t;
    t = 0;
    while (seen_id_q.size() < n) begin
      @(negedge clk);
      t++;
      if (t == WAIT_LIMIT) begin
        timed_out("master AR beats");
      end
    end
  endtask

  // Master AR number k against the slave AR issued as number k
  task automatic check_seen(input int k, input mst_id_t exp_id);
    check_ar(seen_id_q[k], exp_id, seen_addr_q[k], iss_addr_q[k], seen_len_q[k], iss_len_q[k]);
  endtask

  // Memory model answers master AR number k
  // With hold above zero the slave keeps r_ready low on the first beat
  task automatic return_burst(input int k, input int hold);
    int t;
    int last_beat;
    last_beat = int'(seen_len_q[k]);
    for (int b = 0; b <= last_beat; b++) begin
      @(posedge clk);
      mst_r_valid <= 1'b1;
      mst_r_id    <= seen_id_q[k];
      mst_r_data  <= beat_data(seen_addr_q[k], b);
      mst_r_last  <= (b == last_beat);
      if (b == 0 && hold > 0) begin
        slv_r_ready <= 1'b0;
        for (int i = 0; i < hold; i++) begin
          @(negedge clk);
          check_bit("mst_r_ready", mst_r_ready, 1'b0);
          check_bit("slv_r_valid", slv_r_valid, 1'b1);
        end
        @(posedge clk);
        slv_r_ready <= 1'b1;
      end
      // The memory model holds its beat until the converter takes it
      t = 0;
      @(negedge clk);
      while (!(mst_r_valid && mst_r_ready)) begin
        t++;
        if (t == WAIT_LIMIT) begin
          timed_out("master R ready");
        end
        @(negedge clk);
      end
      check_bit("slv_r_valid", slv_r_valid, 1'b1);
      check_r(slv_r_id, iss_wide_q[k], slv_r_data, beat_data(iss_addr_q[k], b),
              slv_r_last, (b == last_beat));
    end
    @(posedge clk);
    mst_r_valid <= 1'b0;
  endtask

  // One read on an empty table takes entry 0
  task automatic test_single();
    clear_books();
    drive_ar(6'h2A, 32'h0000_1000, 8'd3);
    wait_ar_accept();
    wait_seen(1);
    check_seen(0, 2'd0);
    return_burst(0, 0);
  endtask

  // Same wide ID shares one entry up to the per-ID limit
  task automatic test_same_id();
    clear_books();
    for (int i = 0; i < 3; i++) begin
      drive_ar(6'h11, addr_t'(32'h2000 + i * 32'h100), len_t'(i));
      wait_ar_accept();
    end
    drive_ar(6'h11, 32'h0000_2300, 8'd1);
    expect_ar_stall(4);
    wait_seen(3);
    for (int i = 0; i < 3; i++) begin
      check_seen(i, 2'd0);
    end
    return_burst(0, 0);
    wait_ar_accept();
    wait_seen(4);
    check_seen(3, 2'd0);
    for (int i = 1; i < 4; i++) begin
      return_burst(i, 0);
    end
  endtask

  // Four wide IDs fill the table and a fifth waits for a freed entry
  task automatic test_distinct();
    clear_books();
    for (int i = 0; i < 4; i++) begin
      drive_ar(slv_id_t'(i + 1), addr_t'(32'h3000 + i * 32'h100), 8'd1);
      wait_ar_accept();
    end
    drive_ar(6'h05, 32'h0000_3400, 8'd2);
    expect_ar_stall(4);
    wait_seen(4);
    for (int i = 0; i < 4; i++) begin
      check_seen(i, mst_id_t'(i));
    end
    // Entry 2 is freed and must be the one handed out
    return_burst(2, 0);
    wait_ar_accept();
    wait_seen(5);
    check_seen(4, 2'd2);
    return_burst(0, 0);
    return_burst(1, 0);
    return_burst(3, 0);
    return_burst(4, 0);
  endtask

  task automatic test_backpressure();
    clear_books();
    @(posedge clk);
    mst_ar_ready <= 1'b0;
    drive_ar(6'h3F, 32'h0000_4000, 8'd1);
    wait_ar_accept();
    drive_ar(6'h20, 32'h0000_5000, 8'd2);
    // Register is full and the master is not ready, so nothing moves
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_bit("slv_ar_ready", slv_ar_ready, 1'b0);
      check_bit("mst_ar_valid", mst_ar_valid, 1'b1);
      check_ar(mst_ar_id, 2'd0, mst_ar_addr, 32'h0000_4000, mst_ar_len, 8'd1);
    end
    @(posedge clk);
    mst_ar_ready <= 1'b1;
    wait_ar_accept();
    wait_seen(2);
    check_seen(0, 2'd0);
    check_seen(1, 2'd1);
    return_burst(0, 4);
    return_burst(1, 0);
  endtask

  // Rounds of up to three reads that all fit, answered in a shuffled order
  task automatic test_random();
    int      n;
    int      pick;
    int      first;
    int      pos;
    bit      found;
    slv_id_t wide;
    slv_id_t round_ids[$];
    mst_id_t exp_idx[$];
    int      pend[$];
    for (int round = 0; round < 8; round++) begin
      clear_books();
      round_ids.delete();
      exp_idx.delete();
      pend.delete();
      n = 1 + int'(rand_bits(2)) % 3;
      for (int k = 0; k < n; k++) begin
        // Two random bits pick one of four wide IDs, so repeats are common
        wide = slv_id_t'((rand_bits(2) << 4) | 32'h9);
        pos  = -1;
        for (int j = 0; j < round_ids.size(); j++) begin
          if (round_ids[j] == wide) begin
            pos = j;
          end
        end
        // Table starts empty, so a new wide ID takes the next unused entry
        if (pos < 0) begin
          round_ids.push_back(wide);
          pos = round_ids.size() - 1;
        end
        exp_idx.push_back(mst_id_t'(pos));
        drive_ar(wide, addr_t'(rand_bits(16)) << 2, len_t'(rand_bits(2)));
        wait_ar_accept();
        pend.push_back(k);
      end
      wait_seen(n);
      for (int k = 0; k < n; k++) begin
        check_seen(k, exp_idx[k]);
      end
      while (pend.size() > 0) begin
        pick  = int'(rand_bits(2)) % pend.size();
        first = pick;
        found = 1'b0;
        // Bursts on one master ID must come back in issue order
        for (int j = 0; j < pend.size(); j++) begin
          if (!found && seen_id_q[pend[j]] == seen_id_q[pend[pick]]) begin
            first = j;
            found = 1'b1;
          end
        end
        return_burst(pend[first], int'(rand_bits(1)));
        pend.delete(first);
      end
    end
  endtask

  initial begin
    err_count    = 0;
    check_count  = 0;
    lfsr_q       = 32'h516d465e;
    rst          = 1'b1;
    slv_ar_valid = 1'b0;
    slv_ar_id    = '0;
    slv_ar_addr  = '0;
    slv_ar_len   = '0;
    slv_r_ready  = 1'b1;
    mst_ar_ready = 1'b1;
    mst_r_valid  = 1'b0;
    mst_r_id     = '0;
    mst_r_data   = '0;
    mst_r_last   = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("mst_ar_valid", mst_ar_valid, 1'b0);
    check_bit("slv_r_valid", slv_r_valid, 1'b0);
    test_single();
    test_same_id();
    test_distinct();
    test_backpressure();
    test_random();
    repeat (2) @(posedge clk);
    finish_run();
  end

endmodule

// ==== iw_converter.f ====
iw_conv_pkg.sv
remap_alloc_if.sv
id_remap_table.sv
ar_remap_stage.sv
r_restore_stage.sv
iw_converter.sv
tb_iw_converter.sv

// ==== Makefile ====
# Verilator simulation of the read-path ID width converter

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_iw_converter -f iw_converter.f
	./obj_dir/Vtb_iw_converter | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
